/* Makefile */
# Verilator build and run for the mini MCU wrapper testbench

VERILATOR ?= verilator
TOP       ?= tb_mini_mcu_wrapper
FILELIST  ?= list.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build and run the testbench with Verilator"
	@echo "  clean  remove the build directory"
	@echo "variables: VERILATOR TOP FILELIST OBJ_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o V$(TOP)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

/* axil_periph_ctrl.sv */
// ====================
// AXI4-Lite slave, decodes the address and issues one request to a block
// response comes out one cycle after acceptance
// ====================
`default_nettype none

module axil_periph_ctrl (
    input  wire                                  clk_gen,
    input  wire                                  rst_n,
    input  wire  [    mini_mcu_pkg::ADDR_W-1:0]  awaddr_i,
    input  wire                                  awvalid_i,
    output logic                                 awready_o,
    input  wire  [    mini_mcu_pkg::DATA_W-1:0]  wdata_i,
    input  wire  [    mini_mcu_pkg::STRB_W-1:0]  wstrb_i,
    input  wire                                  wvalid_i,
    output logic                                 wready_o,
    output logic [    mini_mcu_pkg::RESP_W-1:0]  bresp_o,
    output logic                                 bvalid_o,
    input  wire                                  bready_i,
    input  wire  [    mini_mcu_pkg::ADDR_W-1:0]  araddr_i,
    input  wire                                  arvalid_i,
    output logic                                 arready_o,
    output logic [    mini_mcu_pkg::DATA_W-1:0]  rdata_o,
    output logic [    mini_mcu_pkg::RESP_W-1:0]  rresp_o,
    output logic                                 rvalid_o,
    input  wire                                  rready_i,
    periph_bus_if.ctrl                           gpio_bus,
    periph_bus_if.ctrl                           exit_bus,
    periph_bus_if.ctrl                           hb_bus
);
  import mini_mcu_pkg::*;

  axil_state_e       state_q;
  periph_sel_e       sel;
  logic              wr_accept;
  logic              rd_accept;
  logic              acc_valid;
  logic [ADDR_W-1:0] acc_addr;
  logic [ OFS_W-1:0] acc_offset;
  logic [DATA_W-1:0] blk_rdata;
  logic              blk_err;
  logic              acc_fail;
  logic [RESP_W-1:0] resp_q;
  logic [DATA_W-1:0] rdata_q;

  // write needs both address and data, and wins over a read
  assign wr_accept = (state_q == IDLE) && awvalid_i && wvalid_i;
  assign rd_accept = (state_q == IDLE) && arvalid_i && !(awvalid_i && wvalid_i);
  assign acc_valid = wr_accept || rd_accept;

  assign awready_o = wr_accept;
  assign wready_o  = wr_accept;
  assign arready_o = rd_accept;

  assign acc_addr   = wr_accept ? awaddr_i : araddr_i;
  assign acc_offset = OFS_W'(acc_addr[BLK_LSB-1:2]);

  always_comb begin
    case (acc_addr[ADDR_W-1:BLK_LSB])
      BLK_GPIO: sel = SEL_GPIO;
      BLK_EXIT: sel = SEL_EXIT;
      BLK_HB:   sel = SEL_HB;
      default:  sel = SEL_NONE;
    endcase
  end

  // unmapped addresses never raise req
  assign gpio_bus.req = acc_valid && (sel == SEL_GPIO);
  assign exit_bus.req = acc_valid && (sel == SEL_EXIT);
  assign hb_bus.req   = acc_valid && (sel == SEL_HB);

  assign gpio_bus.we     = wr_accept;
  assign gpio_bus.offset = acc_offset;
  assign gpio_bus.wdata  = wdata_i;
  assign gpio_bus.wstrb  = wstrb_i;
  assign exit_bus.we     = wr_accept;
  assign exit_bus.offset = acc_offset;
  assign exit_bus.wdata  = wdata_i;
  assign exit_bus.wstrb  = wstrb_i;
  assign hb_bus.we       = wr_accept;
  assign hb_bus.offset   = acc_offset;
  assign hb_bus.wdata    = wdata_i;
  assign hb_bus.wstrb    = wstrb_i;

  always_comb begin
    case (sel)
      SEL_GPIO: begin
        blk_rdata = gpio_bus.rdata;
        blk_err   = gpio_bus.err;
      end
      SEL_EXIT: begin
        blk_rdata = exit_bus.rdata;
        blk_err   = exit_bus.err;
      end
      SEL_HB: begin
        blk_rdata = hb_bus.rdata;
        blk_err   = hb_bus.err;
      end
      default: begin
        blk_rdata = '0;
        blk_err   = 1'b0;
      end
    endcase
  end

  assign acc_fail = (sel == SEL_NONE) || blk_err;

  always_ff @(posedge clk_gen or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= IDLE;
    end else begin
      case (state_q)
        IDLE: begin
          if (wr_accept) begin
            state_q <= WRITE_RESP;
          end else if (rd_accept) begin
            state_q <= READ_RESP;
          end
        end
        WRITE_RESP: begin
          if (bready_i) begin
            state_q <= IDLE;
          end
        end
        READ_RESP: begin
          if (rready_i) begin
            state_q <= IDLE;
          end
        end
        default: state_q <= IDLE;
      endcase
    end
  end

  // response payload held until the host takes it
  always_ff @(posedge clk_gen) begin
    if (acc_valid) begin
      resp_q <= acc_fail ? RESP_SLVERR : RESP_OKAY;
    end
    if (rd_accept) begin
      rdata_q <= acc_fail ? '0 : blk_rdata;
    end
  end

  assign bvalid_o = (state_q == WRITE_RESP);
  assign rvalid_o = (state_q == READ_RESP);
  assign bresp_o  = resp_q;
  assign rresp_o  = resp_q;
  assign rdata_o  = rdata_q;

endmodule

`default_nettype wire

/* exit_status_regs.sv */
// ====================
// exit value with sticky valid flag, plus a scratch word
// ====================
`default_nettype none

module exit_status_regs (
    input  wire                              clk_gen,
    input  wire                              rst_n,
    periph_bus_if.periph                     bus,
    output logic [mini_mcu_pkg::DATA_W-1:0]  exit_value_o,
    output logic                             exit_valid_o
);
  import mini_mcu_pkg::*;

  logic [DATA_W-1:0] exit_value_q;
  logic [DATA_W-1:0] scratch_q;
  logic              exit_valid_q;

  always_comb begin
    bus.rdata = '0;
    bus.err   = 1'b0;
    case (bus.offset)
      OFS_EXIT_VALUE: bus.rdata = exit_value_q;
      OFS_SCRATCH:    bus.rdata = scratch_q;
      default:        bus.err = 1'b1;
    endcase
  end

  always_ff @(posedge clk_gen or negedge rst_n) begin
    if (!rst_n) begin
      exit_value_q <= '0;
      scratch_q    <= '0;
      exit_valid_q <= 1'b0;
    end else if (bus.req && bus.we) begin
      if (bus.offset == OFS_EXIT_VALUE) begin
        exit_value_q <= apply_strb(exit_value_q, bus.wdata, bus.wstrb);
        // only reset clears it
        exit_valid_q <= 1'b1;
      end
      if (bus.offset == OFS_SCRATCH) begin
        scratch_q <= apply_strb(scratch_q, bus.wdata, bus.wstrb);
      end
    end
  end

  assign exit_value_o = exit_value_q;
  assign exit_valid_o = exit_valid_q;

endmodule

`default_nettype wire

/* gpio_regs.sv */
// ====================
// GPIO output, output-enable and synchronized input registers
// ====================
`default_nettype none

module gpio_regs (
    input  wire                              clk_gen,
    input  wire                              rst_n,
    periph_bus_if.periph                     bus,
    input  wire  [mini_mcu_pkg::GPIO_W-1:0]  gpio_i,
    output logic [mini_mcu_pkg::GPIO_W-1:0]  gpio_o,
    output logic [mini_mcu_pkg::GPIO_W-1:0]  gpio_oe_o
);
  import mini_mcu_pkg::*;

  logic [GPIO_W-1:0] out_q;
  logic [GPIO_W-1:0] oe_q;
  logic [GPIO_W-1:0] in_meta_q;
  logic [GPIO_W-1:0] in_sync_q;

  always_comb begin
    bus.rdata = '0;
    bus.err   = 1'b0;
    case (bus.offset)
      OFS_GPIO_OUT: bus.rdata = out_q;
      OFS_GPIO_OE:  bus.rdata = oe_q;
      OFS_GPIO_IN: begin
        bus.rdata = in_sync_q;
        bus.err   = bus.we;
      end
      default: bus.err = 1'b1;
    endcase
  end

  always_ff @(posedge clk_gen or negedge rst_n) begin
    if (!rst_n) begin
      out_q     <= '0;
      oe_q      <= '0;
      in_meta_q <= '0;
      in_sync_q <= '0;
    end else begin
      // two flops against metastability on the pins
      in_meta_q <= gpio_i;
      in_sync_q <= in_meta_q;
      if (bus.req && bus.we) begin
        if (bus.offset == OFS_GPIO_OUT) begin
          out_q <= apply_strb(out_q, bus.wdata, bus.wstrb);
        end
        if (bus.offset == OFS_GPIO_OE) begin
          oe_q <= apply_strb(oe_q, bus.wdata, bus.wstrb);
        end
      end
    end
  end

  assign gpio_o    = out_q;
  assign gpio_oe_o = oe_q;

endmodule

`default_nettype wire

/* heartbeat_regs.sv */
// ====================
// free-running heartbeat counter, LED from its top bit
// ====================
`default_nettype none

module heartbeat_regs #(
    parameter int unsigned count_w = mini_mcu_pkg::HB_COUNT_W_DEF
) (
    input  wire           clk_gen,
    input  wire           rst_n,
    periph_bus_if.periph  bus,
    output logic          led_o
);
  import mini_mcu_pkg::*;

  logic [count_w-1:0] count_q;

  always_ff @(posedge clk_gen or negedge rst_n) begin
    if (!rst_n) begin
      count_q <= '0;
    end else begin
      count_q <= count_q + 1'b1;
    end
  end

  assign led_o = count_q[count_w-1];

  // read-only, count is zero-extended or truncated to the bus width
  always_comb begin
    bus.rdata = '0;
    bus.err   = 1'b1;
    if (bus.offset == OFS_HB_COUNT && !bus.we) begin
      bus.rdata = DATA_W'(count_q);
      bus.err   = 1'b0;
    end
  end

endmodule

`default_nettype wire

/* list.f */
mini_mcu_pkg.sv
periph_bus_if.sv
axil_periph_ctrl.sv
gpio_regs.sv
exit_status_regs.sv
heartbeat_regs.sv
mini_mcu_wrapper.sv
mini_mcu_sva.sv
tb_mini_mcu_wrapper.sv

/* mini_mcu_pkg.sv */
// ====================
// shared widths, register map, response codes and enums
// import into the module body, scoped names in headers
// ====================
`default_nettype none

package mini_mcu_pkg;

  localparam int unsigned ADDR_W = 8;
  localparam int unsigned DATA_W = 32;
  localparam int unsigned STRB_W = DATA_W / 8;
  localparam int unsigned GPIO_W = 32;
  localparam int unsigned RESP_W = 2;
  localparam int unsigned HB_COUNT_W_DEF = 27;

  // block select uses the upper address bits, word offset the rest
  localparam int unsigned BLK_LSB = 4;
  localparam int unsigned BLK_W = ADDR_W - BLK_LSB;
  localparam int unsigned OFS_W = 3;

  localparam logic [ADDR_W-1:0] ADDR_GPIO_OUT = 8'h00;
  localparam logic [ADDR_W-1:0] ADDR_GPIO_OE = 8'h04;
  localparam logic [ADDR_W-1:0] ADDR_GPIO_IN = 8'h08;
  localparam logic [ADDR_W-1:0] ADDR_EXIT_VALUE = 8'h10;
  localparam logic [ADDR_W-1:0] ADDR_SCRATCH = 8'h14;
  localparam logic [ADDR_W-1:0] ADDR_HB_COUNT = 8'h20;

  localparam logic [BLK_W-1:0] BLK_GPIO = ADDR_GPIO_OUT[ADDR_W-1:BLK_LSB];
  localparam logic [BLK_W-1:0] BLK_EXIT = ADDR_EXIT_VALUE[ADDR_W-1:BLK_LSB];
  localparam logic [BLK_W-1:0] BLK_HB = ADDR_HB_COUNT[ADDR_W-1:BLK_LSB];

  // local word offsets seen by the register blocks
  localparam logic [OFS_W-1:0] OFS_GPIO_OUT = OFS_W'(ADDR_GPIO_OUT[BLK_LSB-1:2]);
  localparam logic [OFS_W-1:0] OFS_GPIO_OE = OFS_W'(ADDR_GPIO_OE[BLK_LSB-1:2]);
  localparam logic [OFS_W-1:0] OFS_GPIO_IN = OFS_W'(ADDR_GPIO_IN[BLK_LSB-1:2]);
  localparam logic [OFS_W-1:0] OFS_EXIT_VALUE = OFS_W'(ADDR_EXIT_VALUE[BLK_LSB-1:2]);
  localparam logic [OFS_W-1:0] OFS_SCRATCH = OFS_W'(ADDR_SCRATCH[BLK_LSB-1:2]);
  localparam logic [OFS_W-1:0] OFS_HB_COUNT = OFS_W'(ADDR_HB_COUNT[BLK_LSB-1:2]);

  localparam logic [RESP_W-1:0] RESP_OKAY = 2'd0;
  localparam logic [RESP_W-1:0] RESP_SLVERR = 2'd2;

  typedef enum logic [1:0] {
    IDLE,
    WRITE_RESP,
    READ_RESP
  } axil_state_e;

  typedef enum logic [1:0] {
    SEL_GPIO,
    SEL_EXIT,
    SEL_HB,
    SEL_NONE
  } periph_sel_e;

  // byte lanes with a set strobe take the new data
  function automatic logic [DATA_W-1:0] apply_strb(input logic [DATA_W-1:0] old_val,
                                                  input logic [DATA_W-1:0] new_val,
                                                  input logic [STRB_W-1:0] strb);
    logic [DATA_W-1:0] res;
    res = old_val;
    for (int i = 0; i < STRB_W; i++) begin
      if (strb[i]) begin
        res[8*i+:8] = new_val[8*i+:8];
      end
    end
    return res;
  endfunction

endpackage

`default_nettype wire

/* mini_mcu_sva.sv */
// ====================
// AXI4-Lite response and exit flag assertions, bound into the design
// ====================
`default_nettype none

module mini_mcu_sva (
    input wire                             clk_gen,
    input wire                             rst_n,
    input wire                             bvalid_i,
    input wire                             bready_i,
    input wire [mini_mcu_pkg::RESP_W-1:0]  bresp_i,
    input wire                             rvalid_i,
    input wire                             rready_i,
    input wire [mini_mcu_pkg::RESP_W-1:0]  rresp_i,
    input wire [mini_mcu_pkg::DATA_W-1:0]  rdata_i,
    input wire                             exit_valid_i
);

  // write response held until taken
  assert property (@(posedge clk_gen) disable iff (!rst_n)
      bvalid_i && !bready_i |=> bvalid_i && $stable(bresp_i))
    else $error("bvalid or bresp changed before bready");

  assert property (@(posedge clk_gen) disable iff (!rst_n)
      rvalid_i && !rready_i |=> rvalid_i && $stable(rresp_i) && $stable(rdata_i))
    else $error("rvalid, rresp or rdata changed before rready");

  assert property (@(posedge clk_gen) disable iff (!rst_n) !(bvalid_i && rvalid_i))
    else $error("bvalid and rvalid high together");

  // sticky until reset
  assert property (@(posedge clk_gen) disable iff (!rst_n) exit_valid_i |=> exit_valid_i)
    else $error("exit_valid fell after it was set");

endmodule

bind axil_periph_ctrl mini_mcu_sva i_ctrl_sva (
    .clk_gen     (clk_gen),
    .rst_n       (rst_n),
    .bvalid_i    (bvalid_o),
    .bready_i    (bready_i),
    .bresp_i     (bresp_o),
    .rvalid_i    (rvalid_o),
    .rready_i    (rready_i),
    .rresp_i     (rresp_o),
    .rdata_i     (rdata_o),
    .exit_valid_i(1'b0)
);

bind exit_status_regs mini_mcu_sva i_exit_sva (
    .clk_gen     (clk_gen),
    .rst_n       (rst_n),
    .bvalid_i    (1'b0),
    .bready_i    (1'b0),
    .bresp_i     ('0),
    .rvalid_i    (1'b0),
    .rready_i    (1'b0),
    .rresp_i     ('0),
    .rdata_i     ('0),
    .exit_valid_i(exit_valid_o)
);

`default_nettype wire

/* mini_mcu_wrapper.sv */
// ====================
// board-level wrapper: AXI4-Lite host port, GPIO, exit pins and debug LEDs
// ====================
`default_nettype none

module mini_mcu_wrapper #(
    parameter int unsigned clk_led_count_w = mini_mcu_pkg::HB_COUNT_W_DEF
) (
    input  wire                              clk_gen,
    input  wire                              rst_n,
    input  wire  [mini_mcu_pkg::ADDR_W-1:0]  awaddr_i,
    input  wire                              awvalid_i,
    output logic                             awready_o,
    input  wire  [mini_mcu_pkg::DATA_W-1:0]  wdata_i,
    input  wire  [mini_mcu_pkg::STRB_W-1:0]  wstrb_i,
    input  wire                              wvalid_i,
    output logic                             wready_o,
    output logic [mini_mcu_pkg::RESP_W-1:0]  bresp_o,
    output logic                             bvalid_o,
    input  wire                              bready_i,
    input  wire  [mini_mcu_pkg::ADDR_W-1:0]  araddr_i,
    input  wire                              arvalid_i,
    output logic                             arready_o,
    output logic [mini_mcu_pkg::DATA_W-1:0]  rdata_o,
    output logic [mini_mcu_pkg::RESP_W-1:0]  rresp_o,
    output logic                             rvalid_o,
    input  wire                              rready_i,
    input  wire  [mini_mcu_pkg::GPIO_W-1:0]  gpio_i,
    output logic [mini_mcu_pkg::GPIO_W-1:0]  gpio_o,
    output logic [mini_mcu_pkg::GPIO_W-1:0]  gpio_oe_o,
    output logic                             rst_led_o,
    output logic                             clk_led_o,
    output logic                             clk_out_o,
    output logic                             exit_value_o,
    output logic                             exit_valid_o
);
  import mini_mcu_pkg::*;

  logic [DATA_W-1:0] exit_value;

  periph_bus_if gpio_bus ();
  periph_bus_if exit_bus ();
  periph_bus_if hb_bus ();

  axil_periph_ctrl i_ctrl (
      .clk_gen  (clk_gen),
      .rst_n    (rst_n),
      .awaddr_i (awaddr_i),
      .awvalid_i(awvalid_i),
      .awready_o(awready_o),
      .wdata_i  (wdata_i),
      .wstrb_i  (wstrb_i),
      .wvalid_i (wvalid_i),
      .wready_o (wready_o),
      .bresp_o  (bresp_o),
      .bvalid_o (bvalid_o),
      .bready_i (bready_i),
      .araddr_i (araddr_i),
      .arvalid_i(arvalid_i),
      .arready_o(arready_o),
      .rdata_o  (rdata_o),
      .rresp_o  (rresp_o),
      .rvalid_o (rvalid_o),
      .rready_i (rready_i),
      .gpio_bus (gpio_bus.ctrl),
      .exit_bus (exit_bus.ctrl),
      .hb_bus   (hb_bus.ctrl)
  );

  gpio_regs i_gpio (
      .clk_gen  (clk_gen),
      .rst_n    (rst_n),
      .bus      (gpio_bus.periph),
      .gpio_i   (gpio_i),
      .gpio_o   (gpio_o),
      .gpio_oe_o(gpio_oe_o)
  );

  exit_status_regs i_exit (
      .clk_gen     (clk_gen),
      .rst_n       (rst_n),
      .bus         (exit_bus.periph),
      .exit_value_o(exit_value),
      .exit_valid_o(exit_valid_o)
  );

  // clock LED blinks from the heartbeat counter
  heartbeat_regs #(
      .count_w(clk_led_count_w)
  ) i_hb (
      .clk_gen(clk_gen),
      .rst_n  (rst_n),
      .bus    (hb_bus.periph),
      .led_o  (clk_led_o)
  );

  // debug visibility pins
  assign rst_led_o    = rst_n;
  assign clk_out_o    = clk_gen;
  assign exit_value_o = exit_value[0];

endmodule

`default_nettype wire

/* periph_bus_if.sv */
// ====================
// request/response bus from the AXI4-Lite controller to one register block
// ====================
`default_nettype none

interface periph_bus_if;
  import mini_mcu_pkg::*;

  // one access per cycle while req is high
  logic              req;
  logic              we;
  logic [ OFS_W-1:0] offset;
  logic [DATA_W-1:0] wdata;
  logic [STRB_W-1:0] wstrb;

  // answered combinationally in the req cycle
  logic [DATA_W-1:0] rdata;
  logic              err;

  modport ctrl(
      output req,
      output we,
      output offset,
      output wdata,
      output wstrb,
      input rdata,
      input err
  );

  modport periph(
      input req,
      input we,
      input offset,
      input wdata,
      input wstrb,
      output rdata,
      output err
  );

endinterface

`default_nettype wire

/* tb_mini_mcu_wrapper.sv */
// ====================
// testbench for the wrapper: AXI4-Lite host, register model, compare process
// run as top module, stops on the first mismatch
// ====================
`default_nettype none

module tb_mini_mcu_wrapper;
  import mini_mcu_pkg::*;

  localparam int CLK_PERIOD = 20;
  localparam int RESET_CYCLES = 16;
  localparam int HB_W = 6;
  localparam int NUM_RAND = 8;
  localparam int NUM_STALL_TXN = 24;
  // watchdog allows 200 cycles for each of about 110 bus transactions
  localparam int NUM_TXN = 110;
  localparam int TIMEOUT_CYCLES = NUM_TXN * 200;

  logic              clk_gen;
  logic              rst_n;
  logic [ADDR_W-1:0] awaddr_i;
  logic              awvalid_i;
  logic              awready_o;
  logic [DATA_W-1:0] wdata_i;
  logic [STRB_W-1:0] wstrb_i;
  logic              wvalid_i;
  logic              wready_o;
  logic [RESP_W-1:0] bresp_o;
  logic              bvalid_o;
  logic              bready_i;
  logic [ADDR_W-1:0] araddr_i;
  logic              arvalid_i;
  logic              arready_o;
  logic [DATA_W-1:0] rdata_o;
  logic [RESP_W-1:0] rresp_o;
  logic              rvalid_o;
  logic              rready_i;
  logic [GPIO_W-1:0] gpio_i;
  logic [GPIO_W-1:0] gpio_o;
  logic [GPIO_W-1:0] gpio_oe_o;
  logic              rst_led_o;
  logic              clk_led_o;
  logic              clk_out_o;
  logic              exit_value_o;
  logic              exit_valid_o;

  integer            seed;
  int                stall_max;
  logic [31:0]       cyc_cnt;

  // register model state
  logic [DATA_W-1:0] m_out;
  logic [DATA_W-1:0] m_oe;
  logic [DATA_W-1:0] m_exit;
  logic [DATA_W-1:0] m_scratch;
  logic              m_valid;

  // pending checks drained by the compare process
  string             name_q[$];
  logic [DATA_W-1:0] exp_q[$];
  logic [DATA_W-1:0] act_q[$];

  mini_mcu_wrapper #(
      .clk_led_count_w(HB_W)
  ) i_dut (
      .clk_gen     (clk_gen),
      .rst_n       (rst_n),
      .awaddr_i    (awaddr_i),
      .awvalid_i   (awvalid_i),
      .awready_o   (awready_o),
      .wdata_i     (wdata_i),
      .wstrb_i     (wstrb_i),
      .wvalid_i    (wvalid_i),
      .wready_o    (wready_o),
      .bresp_o     (bresp_o),
      .bvalid_o    (bvalid_o),
      .bready_i    (bready_i),
      .araddr_i    (araddr_i),
      .arvalid_i   (arvalid_i),
      .arready_o   (arready_o),
      .rdata_o     (rdata_o),
      .rresp_o     (rresp_o),
      .rvalid_o    (rvalid_o),
      .rready_i    (rready_i),
      .gpio_i      (gpio_i),
      .gpio_o      (gpio_o),
      .gpio_oe_o   (gpio_oe_o),
      .rst_led_o   (rst_led_o),
      .clk_led_o   (clk_led_o),
      .clk_out_o   (clk_out_o),
      .exit_value_o(exit_value_o),
      .exit_valid_o(exit_valid_o)
  );

  always #(CLK_PERIOD / 2) clk_gen = ~clk_gen;

  // cycles since reset release as the heartbeat reference
  always @(posedge clk_gen or negedge rst_n) begin
    if (!rst_n) begin
      cyc_cnt <= '0;
    end else begin
      cyc_cnt <= cyc_cnt + 32'd1;
    end
  end

  // reference register map, returns {resp, rdata} and updates the model on writes
  function automatic logic [RESP_W+DATA_W-1:0] model_access(
      input logic we, input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] wdata,
      input logic [STRB_W-1:0] strb, input logic [GPIO_W-1:0] pins, input logic [31:0] cycles);
    logic [DATA_W-1:0] mask;
    logic [DATA_W-1:0] rdata;
    logic [RESP_W-1:0] resp;
    for (int b = 0; b < STRB_W; b++) begin
      mask[8*b+:8] = {8{strb[b]}};
    end
    rdata = '0;
    resp  = RESP_OKAY;
    case (addr)
      ADDR_GPIO_OUT: begin
        if (we) begin
          m_out = (m_out & ~mask) | (wdata & mask);
        end
        rdata = m_out;
      end
      ADDR_GPIO_OE: begin
        if (we) begin
          m_oe = (m_oe & ~mask) | (wdata & mask);
        end
        rdata = m_oe;
      end
      ADDR_GPIO_IN: begin
        resp  = we ? RESP_SLVERR : RESP_OKAY;
        rdata = pins;
      end
      ADDR_EXIT_VALUE: begin
        if (we) begin
          m_exit  = (m_exit & ~mask) | (wdata & mask);
          m_valid = 1'b1;
        end
        rdata = m_exit;
      end
      ADDR_SCRATCH: begin
        if (we) begin
          m_scratch = (m_scratch & ~mask) | (wdata & mask);
        end
        rdata = m_scratch;
      end
      ADDR_HB_COUNT: begin
        resp  = we ? RESP_SLVERR : RESP_OKAY;
        rdata = DATA_W'(cycles[HB_W-1:0]);
      end
      default: resp = RESP_SLVERR;
    endcase
    return {resp, rdata};
  endfunction

  task automatic expect_eq(input string name, input logic [DATA_W-1:0] exp_val,
                           input logic [DATA_W-1:0] act_val);
    name_q.push_back(name);
    exp_q.push_back(exp_val);
    act_q.push_back(act_val);
  endtask

  // starts at a falling edge, returns at a falling edge with the bus idle
  task automatic write_reg(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data,
                           input logic [STRB_W-1:0] strb, output logic [RESP_W-1:0] resp);
    int stall;
    awaddr_i  = addr;
    awvalid_i = 1'b1;
    wdata_i   = data;
    wstrb_i   = strb;
    wvalid_i  = 1'b1;
    @(posedge clk_gen);
    expect_eq("awready and wready on accept", 32'd3, 32'({awready_o, wready_o}));
    do begin
      @(negedge clk_gen);
    end while (!bvalid_o);
    awvalid_i = 1'b0;
    wvalid_i  = 1'b0;
    resp      = bresp_o;
    stall     = $unsigned($random(seed)) % (stall_max + 1);
    repeat (stall) begin
      @(negedge clk_gen);
      expect_eq("bvalid held", 32'd1, 32'(bvalid_o));
      expect_eq("bresp held", 32'(resp), 32'(bresp_o));
    end
    bready_i = 1'b1;
    @(negedge clk_gen);
    bready_i = 1'b0;
  endtask

  task automatic read_reg(input logic [ADDR_W-1:0] addr, output logic [DATA_W-1:0] data,
                          output logic [RESP_W-1:0] resp);
    int stall;
    araddr_i  = addr;
    arvalid_i = 1'b1;
    @(posedge clk_gen);
    expect_eq("arready on accept", 32'd1, 32'(arready_o));
    do begin
      @(negedge clk_gen);
    end while (!rvalid_o);
    arvalid_i = 1'b0;
    data      = rdata_o;
    resp      = rresp_o;
    stall     = $unsigned($random(seed)) % (stall_max + 1);
    repeat (stall) begin
      @(negedge clk_gen);
      expect_eq("rvalid held", 32'd1, 32'(rvalid_o));
      expect_eq("rdata held", data, rdata_o);
      expect_eq("rresp held", 32'(resp), 32'(rresp_o));
    end
    rready_i = 1'b1;
    @(negedge clk_gen);
    rready_i = 1'b0;
  endtask

  task automatic verify_write(input string name, input logic [ADDR_W-1:0] addr,
                              input logic [DATA_W-1:0] data, input logic [STRB_W-1:0] strb);
    logic [RESP_W+DATA_W-1:0] exp_val;
    logic [RESP_W-1:0]        resp;
    exp_val = model_access(1'b1, addr, data, strb, gpio_i, cyc_cnt);
    write_reg(addr, data, strb, resp);
    expect_eq({name, " bresp"}, 32'(exp_val[DATA_W+:RESP_W]), 32'(resp));
  endtask

  // expected value is taken at the drive edge before the address is accepted
  task automatic verify_read(input string name, input logic [ADDR_W-1:0] addr,
                             output logic [DATA_W-1:0] data);
    logic [RESP_W+DATA_W-1:0] exp_val;
    logic [RESP_W-1:0]        resp;
    exp_val = model_access(1'b0, addr, '0, '0, gpio_i, cyc_cnt);
    read_reg(addr, data, resp);
    expect_eq({name, " rdata"}, exp_val[DATA_W-1:0], data);
    expect_eq({name, " rresp"}, 32'(exp_val[DATA_W+:RESP_W]), 32'(resp));
  endtask

  always @(negedge clk_gen) begin
    string             name;
    logic [DATA_W-1:0] exp_val;
    logic [DATA_W-1:0] act_val;
    while (exp_q.size() > 0) begin
      name    = name_q.pop_front();
      exp_val = exp_q.pop_front();
      act_val = act_q.pop_front();
      assert (act_val === exp_val)
      else begin
        $display("[FAIL] %s: expected %h, actual %h", name, exp_val, act_val);
        $display("TEST RESULT: FAIL");
        $fatal(1, "value mismatch");
      end
    end
  end

  initial begin
    repeat (TIMEOUT_CYCLES) @(posedge clk_gen);
    $display("ERROR: simulation did not finish within %0d cycles", TIMEOUT_CYCLES);
    $display("TEST RESULT: FAIL");
    $fatal(1, "watchdog timeout");
  end

  initial begin
    logic [DATA_W-1:0] rd;
    logic [DATA_W-1:0] hb_first;
    logic [DATA_W-1:0] data;
    logic [STRB_W-1:0] strb;
    logic [ADDR_W-1:0] rw_addrs[3];
    logic [ADDR_W-1:0] all_addrs[8];
    logic [2:0]        pick;
    int                gap;
    int                led_gap;
    logic              led_prev;
    logic              led_seen;

    seed      = 32'h15905a12;
    stall_max = 3;
    clk_gen   = 1'b0;
    rst_n     = 1'b0;
    awaddr_i  = '0;
    awvalid_i = 1'b0;
    wdata_i   = '0;
    wstrb_i   = '0;
    wvalid_i  = 1'b0;
    bready_i  = 1'b0;
    araddr_i  = '0;
    arvalid_i = 1'b0;
    rready_i  = 1'b0;
    gpio_i    = '0;
    m_out     = '0;
    m_oe      = '0;
    m_exit    = '0;
    m_scratch = '0;
    m_valid   = 1'b0;
    rw_addrs[0] = ADDR_GPIO_OUT;
    rw_addrs[1] = ADDR_GPIO_OE;
    rw_addrs[2] = ADDR_SCRATCH;
    all_addrs[0] = ADDR_GPIO_OUT;
    all_addrs[1] = ADDR_GPIO_OE;
    all_addrs[2] = ADDR_GPIO_IN;
    all_addrs[3] = 8'h0c;
    all_addrs[4] = ADDR_EXIT_VALUE;
    all_addrs[5] = ADDR_SCRATCH;
    all_addrs[6] = ADDR_HB_COUNT;
    all_addrs[7] = 8'h30;

    // state after reset
    repeat (RESET_CYCLES) @(negedge clk_gen);
    expect_eq("rst_led_o in reset", 32'd0, 32'(rst_led_o));
    expect_eq("ready in reset", 32'd0, 32'({awready_o, wready_o, arready_o}));
    rst_n = 1'b1;
    @(negedge clk_gen);
    expect_eq("rst_led_o after reset", 32'd1, 32'(rst_led_o));
    expect_eq("valid after reset", 32'd0, 32'({bvalid_o, rvalid_o, exit_valid_o}));
    for (int i = 0; i < 8; i++) begin
      if (i != 3 && i != 7) begin
        verify_read("reset read", all_addrs[i], rd);
      end
    end

    // GPIO and scratch with random strobes
    for (int i = 0; i < NUM_RAND; i++) begin
      for (int r = 0; r < 3; r++) begin
        data = $random(seed);
        strb = STRB_W'($random(seed));
        verify_write("rand write", rw_addrs[r], data, strb);
        verify_read("rand readback", rw_addrs[r], rd);
      end
      expect_eq("gpio_o pins", m_out, gpio_o);
      expect_eq("gpio_oe_o pins", m_oe, gpio_oe_o);
      gpio_i = $random(seed);
      repeat (3) @(negedge clk_gen);
      verify_read("gpio_in sync", ADDR_GPIO_IN, rd);
    end

    // error responses leave every register untouched
    verify_write("write gpio_in", ADDR_GPIO_IN, $random(seed), 4'hf);
    verify_write("write hb_count", ADDR_HB_COUNT, $random(seed), 4'hf);
    verify_write("write unmapped", 8'h30, $random(seed), 4'hf);
    verify_read("read unmapped", 8'h30, rd);
    for (int r = 0; r < 3; r++) begin
      verify_read("after error", rw_addrs[r], rd);
    end
    verify_read("after error", ADDR_EXIT_VALUE, rd);

    // exit flag is sticky
    data = $random(seed);
    verify_write("exit write", ADDR_EXIT_VALUE, data, 4'hf);
    expect_eq("exit_valid_o set", 32'd1, 32'(exit_valid_o));
    expect_eq("exit_value_o bit", 32'(data[0]), 32'(exit_value_o));
    verify_write("exit rewrite", ADDR_EXIT_VALUE, ~data, 4'h1);
    expect_eq("exit_valid_o sticky", 32'd1, 32'(exit_valid_o));
    expect_eq("exit_value_o rewrite", 32'(!data[0]), 32'(exit_value_o));
    verify_read("exit readback", ADDR_EXIT_VALUE, rd);
    verify_write("scratch write", ADDR_SCRATCH, $random(seed), 4'hf);
    expect_eq("exit_valid_o held", 32'd1, 32'(exit_valid_o));

    // each heartbeat read spans two cycles from drive to the next drive
    stall_max = 0;
    gap = 10;
    verify_read("hb first", ADDR_HB_COUNT, hb_first);
    repeat (gap) @(negedge clk_gen);
    verify_read("hb second", ADDR_HB_COUNT, rd);
    expect_eq("hb delta", 32'((gap + 2) % 64), (rd - hb_first) & 32'h3f);
    led_prev = clk_led_o;
    led_seen = 1'b0;
    led_gap  = 0;
    repeat (140) begin
      @(negedge clk_gen);
      led_gap++;
      expect_eq("clk_out_o low phase", 32'd0, 32'(clk_out_o));
      expect_eq("clk_led_o top bit", 32'(cyc_cnt[HB_W-1]), 32'(clk_led_o));
      if (clk_led_o != led_prev) begin
        if (led_seen) begin
          expect_eq("clk_led_o period", 32'd32, 32'(led_gap));
        end
        led_seen = 1'b1;
        led_gap  = 0;
        led_prev = clk_led_o;
      end
    end
    expect_eq("clk_led_o toggled", 32'd1, 32'(led_seen));
    #(CLK_PERIOD * 3 / 4);
    expect_eq("clk_out_o high phase", 32'd1, 32'(clk_out_o));
    @(negedge clk_gen);

    // back-pressure on random targets
    stall_max = 7;
    for (int i = 0; i < NUM_STALL_TXN; i++) begin
      pick = 3'($random(seed));
      if ($random(seed) & 1) begin
        verify_write("stall write", all_addrs[pick], $random(seed), STRB_W'($random(seed)));
      end else begin
        verify_read("stall read", all_addrs[pick], rd);
      end
    end
    expect_eq("gpio_o final", m_out, gpio_o);
    expect_eq("exit_valid_o final", 32'(m_valid), 32'(exit_valid_o));

    repeat (2) @(negedge clk_gen);
    if (exp_q.size() != 0) begin
      $display("ERROR: %0d checks were never compared", exp_q.size());
      $display("TEST RESULT: FAIL");
      $fatal(1, "compare queue not drained");
    end else begin
      $display("TEST RESULT: PASS");
      $finish;
    end
  end

endmodule

`default_nettype wire
